// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Logical word and write lanes.
  localparam int LANE_W    = 8;
  localparam int NUM_LANES = 4;
  localparam int WORD_W    = LANE_W * NUM_LANES;

  // Address split: bank in the low bits, logical row above it.
  localparam int NUM_BANKS = 4;
  localparam int BANK_W    = 2;
  localparam int VROW_W    = 6;
  localparam int ADDR_W    = BANK_W + VROW_W;

  // Several logical words share one physical row.
  localparam int WORDS_PER_ROW = 4;
  localparam int WSEL_W        = 2;
  localparam int PROW_W        = VROW_W - WSEL_W;
  localparam int PHY_W         = WORDS_PER_ROW * WORD_W;

  // Bank macro read latency in cycles.
  localparam int RD_DELAY = 2;

  // Refresh sub-banks, taken from the top bits of the physical row.
  localparam int NUM_RBANKS = 4;
  localparam int RBANK_W    = 2;
  localparam int REF_PERIOD = 16;

endpackage

`default_nettype wire

// File: bank/word_align.sv
`default_nettype none

module word_align (
  input  wire                           clk,
  input  wire                           arst_n,
  input  wire                           bank_read,
  input  wire                           bank_write,
  input  wire  [mem_pkg::VROW_W-1:0]    bank_vrow,
  input  wire  [mem_pkg::WORD_W-1:0]    bank_mask,
  input  wire  [mem_pkg::WORD_W-1:0]    bank_din,
  input  wire  [mem_pkg::PHY_W-1:0]     t1_dout,
  output logic [mem_pkg::WORD_W-1:0]    bank_dout,
  output logic                          t1_read,
  output logic                          t1_write,
  output logic [mem_pkg::PROW_W-1:0]    t1_addr,
  output logic [mem_pkg::PHY_W-1:0]     t1_bw,
  output logic [mem_pkg::PHY_W-1:0]     t1_din
);

  logic [mem_pkg::PROW_W-1:0] prow;
  logic [mem_pkg::WSEL_W-1:0] wsel;

  // Slot of each read, aligned with the macro data.
  logic [mem_pkg::WSEL_W-1:0] sel_pipe [mem_pkg::RD_DELAY];

  assign prow = bank_vrow[mem_pkg::VROW_W-1:mem_pkg::WSEL_W];
  assign wsel = bank_vrow[mem_pkg::WSEL_W-1:0];

  assign t1_read  = bank_read;
  assign t1_write = bank_write;
  assign t1_addr  = prow;

  // Mask and data land in the selected slot only.
  always_comb begin
    for (int s = 0; s < mem_pkg::WORDS_PER_ROW; s++) begin
      if (bank_write && (int'(wsel) == s)) begin
        t1_bw[s*mem_pkg::WORD_W +: mem_pkg::WORD_W]  = bank_mask;
        t1_din[s*mem_pkg::WORD_W +: mem_pkg::WORD_W] = bank_din;
      end else begin
        t1_bw[s*mem_pkg::WORD_W +: mem_pkg::WORD_W]  = '0;
        t1_din[s*mem_pkg::WORD_W +: mem_pkg::WORD_W] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    sel_pipe[0] <= wsel;
    for (int i = 1; i < mem_pkg::RD_DELAY; i++) begin
      sel_pipe[i] <= sel_pipe[i-1];
    end
  end

  // Pick the requested word out of the returned row.
  assign bank_dout = t1_dout[int'(sel_pipe[mem_pkg::RD_DELAY-1])*mem_pkg::WORD_W +:
                             mem_pkg::WORD_W];

  a_one_access: assert property (@(posedge clk) disable iff (!arst_n)
    !(t1_read && t1_write))
    else $error("read and write to one bank macro in one cycle");

endmodule

`default_nettype wire

// File: bank/bank_refresh.sv
`default_nettype none

module bank_refresh (
  input  wire                           clk,
  input  wire                           arst_n,
  input  wire                           refr,
  input  wire                           bank_access,
  input  wire  [mem_pkg::RBANK_W-1:0]   access_rbank,
  output logic                          t1_refr,
  output logic [mem_pkg::RBANK_W-1:0]   t1_rbank
);

  logic                         pending_q;
  logic [mem_pkg::RBANK_W-1:0]  rbank_q;
  logic                         want_refr;
  logic                         conflict;
  int unsigned                  refr_gap_q;

  assign want_refr = pending_q || refr;
  assign conflict  = bank_access && (access_rbank == rbank_q);

  // Refresh goes out in the first cycle without a same sub-bank access.
  assign t1_refr  = want_refr && !conflict;
  assign t1_rbank = rbank_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending_q <= 1'b0;
      rbank_q   <= '0;
    end else begin
      pending_q <= want_refr && !t1_refr;
      if (t1_refr) begin
        if (int'(rbank_q) == mem_pkg::NUM_RBANKS - 1) begin
          rbank_q <= '0;
        end else begin
          rbank_q <= rbank_q + 1'b1;
        end
      end
    end
  end

  // Cycles since the last refr, saturating.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      refr_gap_q <= mem_pkg::REF_PERIOD;
    end else if (refr) begin
      refr_gap_q <= 1;
    end else if (refr_gap_q < mem_pkg::REF_PERIOD) begin
      refr_gap_q <= refr_gap_q + 1;
    end
  end

  a_refr_not_pending: assert property (@(posedge clk) disable iff (!arst_n)
    refr |-> !pending_q)
    else $error("refr while a refresh is still pending");

  a_refr_period: assert property (@(posedge clk) disable iff (!arst_n)
    refr |-> (refr_gap_q >= mem_pkg::REF_PERIOD))
    else $error("refr pulses closer than the refresh period");

endmodule

`default_nettype wire

// File: source/bank_router.sv
`default_nettype none

module bank_router (
  input  wire                                            clk,
  input  wire                                            arst_n,
  input  wire                                            write,
  input  wire  [mem_pkg::ADDR_W-1:0]                     wr_adr,
  input  wire  [mem_pkg::NUM_LANES-1:0]                  wren,
  input  wire  [mem_pkg::WORD_W-1:0]                     din,
  input  wire                                            read,
  input  wire  [mem_pkg::ADDR_W-1:0]                     rd_adr,
  input  wire  [mem_pkg::NUM_BANKS*mem_pkg::WORD_W-1:0]  bank_dout,
  output logic                                           ready,
  output logic                                           rd_vld,
  output logic [mem_pkg::WORD_W-1:0]                     rd_dout,
  output logic [mem_pkg::NUM_BANKS-1:0]                  bank_read,
  output logic [mem_pkg::NUM_BANKS-1:0]                  bank_write,
  output logic [mem_pkg::NUM_BANKS*mem_pkg::VROW_W-1:0]  bank_vrow,
  output logic [mem_pkg::NUM_BANKS*mem_pkg::WORD_W-1:0]  bank_mask,
  output logic [mem_pkg::NUM_BANKS*mem_pkg::WORD_W-1:0]  bank_din
);

  logic                         ready_q;
  logic                         rd_go;
  logic                         wr_go;
  logic [mem_pkg::BANK_W-1:0]   rd_bank;
  logic [mem_pkg::BANK_W-1:0]   wr_bank;
  logic [mem_pkg::VROW_W-1:0]   rd_vrow;
  logic [mem_pkg::VROW_W-1:0]   wr_vrow;
  logic [mem_pkg::WORD_W-1:0]   wr_mask;

  // Reads in flight, one stage per cycle of bank latency.
  logic                         vld_pipe  [mem_pkg::RD_DELAY];
  logic [mem_pkg::BANK_W-1:0]   bank_pipe [mem_pkg::RD_DELAY];

  // Ready rises one cycle after reset is released.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  assign ready = ready_q;
  assign rd_go = read && ready_q;
  assign wr_go = write && ready_q;

  assign rd_bank = rd_adr[mem_pkg::BANK_W-1:0];
  assign rd_vrow = rd_adr[mem_pkg::ADDR_W-1:mem_pkg::BANK_W];
  assign wr_bank = wr_adr[mem_pkg::BANK_W-1:0];
  assign wr_vrow = wr_adr[mem_pkg::ADDR_W-1:mem_pkg::BANK_W];

  // Lane enables to a bit mask.
  always_comb begin
    for (int l = 0; l < mem_pkg::NUM_LANES; l++) begin
      wr_mask[l*mem_pkg::LANE_W +: mem_pkg::LANE_W] = {mem_pkg::LANE_W{wren[l]}};
    end
  end

  always_comb begin
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      bank_read[b]  = rd_go && (int'(rd_bank) == b);
      bank_write[b] = wr_go && (int'(wr_bank) == b);
      bank_vrow[b*mem_pkg::VROW_W +: mem_pkg::VROW_W] = bank_read[b] ? rd_vrow : wr_vrow;
      bank_mask[b*mem_pkg::WORD_W +: mem_pkg::WORD_W] = bank_write[b] ? wr_mask : '0;
      bank_din[b*mem_pkg::WORD_W +: mem_pkg::WORD_W]  = din;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < mem_pkg::RD_DELAY; i++) begin
        vld_pipe[i] <= 1'b0;
      end
    end else begin
      vld_pipe[0] <= rd_go;
      for (int i = 1; i < mem_pkg::RD_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank_pipe[0] <= rd_bank;
    for (int i = 1; i < mem_pkg::RD_DELAY; i++) begin
      bank_pipe[i] <= bank_pipe[i-1];
    end
  end

  assign rd_vld  = vld_pipe[mem_pkg::RD_DELAY-1];
  assign rd_dout = bank_dout[int'(bank_pipe[mem_pkg::RD_DELAY-1])*mem_pkg::WORD_W +:
                             mem_pkg::WORD_W];

  // Single-port macros, so read and write must hit different banks.
  a_rd_wr_bank: assert property (@(posedge clk) disable iff (!arst_n)
    !(rd_go && wr_go && (rd_bank == wr_bank)))
    else $error("read and write to bank %0d in one cycle", rd_bank);

endmodule

`default_nettype wire

// File: source/bank_mem_top.sv
`default_nettype none

module bank_mem_top (
  input  wire                                           clk,
  input  wire                                           arst_n,
  input  wire                                           refr,
  input  wire                                           write,
  input  wire  [mem_pkg::ADDR_W-1:0]                    wr_adr,
  input  wire  [mem_pkg::NUM_LANES-1:0]                 wren,
  input  wire  [mem_pkg::WORD_W-1:0]                    din,
  input  wire                                           read,
  input  wire  [mem_pkg::ADDR_W-1:0]                    rd_adr,
  input  wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0]  t1_dout,
  output wire                                           ready,
  output wire                                           rd_vld,
  output wire  [mem_pkg::WORD_W-1:0]                    rd_dout,
  output wire  [mem_pkg::NUM_BANKS-1:0]                 t1_read,
  output wire  [mem_pkg::NUM_BANKS-1:0]                 t1_write,
  output wire  [mem_pkg::NUM_BANKS*mem_pkg::PROW_W-1:0] t1_addr,
  output wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0]  t1_bw,
  output wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0]  t1_din,
  output wire  [mem_pkg::NUM_BANKS-1:0]                 t1_refr,
  output wire  [mem_pkg::NUM_BANKS*mem_pkg::RBANK_W-1:0] t1_rbank
);

  logic [mem_pkg::NUM_BANKS-1:0]                bank_read;
  logic [mem_pkg::NUM_BANKS-1:0]                bank_write;
  logic [mem_pkg::NUM_BANKS*mem_pkg::VROW_W-1:0] bank_vrow;
  logic [mem_pkg::NUM_BANKS*mem_pkg::WORD_W-1:0] bank_mask;
  logic [mem_pkg::NUM_BANKS*mem_pkg::WORD_W-1:0] bank_din;
  wire  [mem_pkg::NUM_BANKS*mem_pkg::WORD_W-1:0] bank_dout;

  bank_router bank_router_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .write      (write),
    .wr_adr     (wr_adr),
    .wren       (wren),
    .din        (din),
    .read       (read),
    .rd_adr     (rd_adr),
    .bank_dout  (bank_dout),
    .ready      (ready),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout),
    .bank_read  (bank_read),
    .bank_write (bank_write),
    .bank_vrow  (bank_vrow),
    .bank_mask  (bank_mask),
    .bank_din   (bank_din)
  );

  genvar b;
  generate
    for (b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_bank
      wire [mem_pkg::PROW_W-1:0]  prow;
      wire [mem_pkg::RBANK_W-1:0] access_rbank;
      wire                        bank_access;

      word_align word_align_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .bank_read  (bank_read[b]),
        .bank_write (bank_write[b]),
        .bank_vrow  (bank_vrow[b*mem_pkg::VROW_W +: mem_pkg::VROW_W]),
        .bank_mask  (bank_mask[b*mem_pkg::WORD_W +: mem_pkg::WORD_W]),
        .bank_din   (bank_din[b*mem_pkg::WORD_W +: mem_pkg::WORD_W]),
        .t1_dout    (t1_dout[b*mem_pkg::PHY_W +: mem_pkg::PHY_W]),
        .bank_dout  (bank_dout[b*mem_pkg::WORD_W +: mem_pkg::WORD_W]),
        .t1_read    (t1_read[b]),
        .t1_write   (t1_write[b]),
        .t1_addr    (prow),
        .t1_bw      (t1_bw[b*mem_pkg::PHY_W +: mem_pkg::PHY_W]),
        .t1_din     (t1_din[b*mem_pkg::PHY_W +: mem_pkg::PHY_W])
      );

      assign t1_addr[b*mem_pkg::PROW_W +: mem_pkg::PROW_W] = prow;

      // Sub-bank of the current access.
      assign access_rbank = prow[mem_pkg::PROW_W-1 -: mem_pkg::RBANK_W];
      assign bank_access  = t1_read[b] | t1_write[b];

      bank_refresh bank_refresh_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .refr         (refr),
        .bank_access  (bank_access),
        .access_rbank (access_rbank),
        .t1_refr      (t1_refr[b]),
        .t1_rbank     (t1_rbank[b*mem_pkg::RBANK_W +: mem_pkg::RBANK_W])
      );
    end
  endgenerate

endmodule

`default_nettype wire

// File: sim/bank_model.sv
`default_nettype none

module bank_model (
  input  wire                                            clk,
  input  wire  [mem_pkg::NUM_BANKS-1:0]                  t1_read,
  input  wire  [mem_pkg::NUM_BANKS-1:0]                  t1_write,
  input  wire  [mem_pkg::NUM_BANKS*mem_pkg::PROW_W-1:0]  t1_addr,
  input  wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0]   t1_bw,
  input  wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0]   t1_din,
  output logic [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0]   t1_dout
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [mem_pkg::PHY_W-1:0] mem     [mem_pkg::NUM_BANKS][1 << mem_pkg::PROW_W];
  logic [mem_pkg::PHY_W-1:0] rd_pipe [mem_pkg::NUM_BANKS][mem_pkg::RD_DELAY];

  // Macros start out cleared.
  initial begin
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      for (int r = 0; r < (1 << mem_pkg::PROW_W); r++) begin
        mem[b][r] = '0;
      end
      for (int i = 0; i < mem_pkg::RD_DELAY; i++) begin
        rd_pipe[b][i] = '0;
      end
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      if (t1_write[b]) begin
        mem[b][t1_addr[b*mem_pkg::PROW_W +: mem_pkg::PROW_W]] <=
          (mem[b][t1_addr[b*mem_pkg::PROW_W +: mem_pkg::PROW_W]] &
           ~t1_bw[b*mem_pkg::PHY_W +: mem_pkg::PHY_W]) |
          (t1_din[b*mem_pkg::PHY_W +: mem_pkg::PHY_W] & t1_bw[b*mem_pkg::PHY_W +: mem_pkg::PHY_W]);
      end
      if (t1_read[b]) begin
        rd_pipe[b][0] <= mem[b][t1_addr[b*mem_pkg::PROW_W +: mem_pkg::PROW_W]];
      end
      for (int i = 1; i < mem_pkg::RD_DELAY; i++) begin
        rd_pipe[b][i] <= rd_pipe[b][i-1];
      end
    end
  end

  // Row data shows up RD_DELAY edges after the read.
  always_comb begin
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      t1_dout[b*mem_pkg::PHY_W +: mem_pkg::PHY_W] = rd_pipe[b][mem_pkg::RD_DELAY-1];
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_bank_mem.sv
`default_nettype none

module tb_bank_mem;

  timeunit 1ns;
  timeprecision 1ps;

  logic                                         clk;
  logic                                         arst_n;
  logic                                         refr;
  logic                                         write;
  logic [mem_pkg::ADDR_W-1:0]                   wr_adr;
  logic [mem_pkg::NUM_LANES-1:0]                wren;
  logic [mem_pkg::WORD_W-1:0]                   din;
  logic                                         read;
  logic [mem_pkg::ADDR_W-1:0]                   rd_adr;
  wire                                          ready;
  wire                                          rd_vld;
  wire  [mem_pkg::WORD_W-1:0]                   rd_dout;
  wire  [mem_pkg::NUM_BANKS-1:0]                t1_read;
  wire  [mem_pkg::NUM_BANKS-1:0]                t1_write;
  wire  [mem_pkg::NUM_BANKS*mem_pkg::PROW_W-1:0] t1_addr;
  wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0] t1_bw;
  wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0] t1_din;
  wire  [mem_pkg::NUM_BANKS*mem_pkg::PHY_W-1:0] t1_dout;
  wire  [mem_pkg::NUM_BANKS-1:0]                t1_refr;
  wire  [mem_pkg::NUM_BANKS*mem_pkg::RBANK_W-1:0] t1_rbank;

  logic [mem_pkg::WORD_W-1:0]  shadow    [1 << mem_pkg::ADDR_W];
  logic [mem_pkg::WORD_W-1:0]  exp_q     [$];
  logic                        rd_hist   [mem_pkg::RD_DELAY];
  logic [mem_pkg::RBANK_W-1:0] exp_rbank [mem_pkg::NUM_BANKS];
  logic [mem_pkg::NUM_BANKS-1:0] pend;
  logic                        mon_on;
  int                          since;

  bank_mem_top bank_mem_top_inst (
    .clk(clk), .arst_n(arst_n), .refr(refr), .write(write), .wr_adr(wr_adr),
    .wren(wren), .din(din), .read(read), .rd_adr(rd_adr), .t1_dout(t1_dout),
    .ready(ready), .rd_vld(rd_vld), .rd_dout(rd_dout), .t1_read(t1_read),
    .t1_write(t1_write), .t1_addr(t1_addr), .t1_bw(t1_bw), .t1_din(t1_din),
    .t1_refr(t1_refr), .t1_rbank(t1_rbank)
  );

  bank_model bank_model_inst (
    .clk(clk), .t1_read(t1_read), .t1_write(t1_write), .t1_addr(t1_addr),
    .t1_bw(t1_bw), .t1_din(t1_din), .t1_dout(t1_dout)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s at %0t", msg, $time);
    abort_run();
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Returns the stored word, then merges a write under its lanes.
  function automatic logic [mem_pkg::WORD_W-1:0] ref_word(
    input logic [mem_pkg::ADDR_W-1:0]    adr,
    input logic                          wr,
    input logic [mem_pkg::NUM_LANES-1:0] lanes,
    input logic [mem_pkg::WORD_W-1:0]    data
  );
    logic [mem_pkg::WORD_W-1:0] old;
    logic [mem_pkg::WORD_W-1:0] nxt;
    old = shadow[adr];
    nxt = old;
    for (int l = 0; l < mem_pkg::NUM_LANES; l++) begin
      if (lanes[l]) begin
        nxt[l*mem_pkg::LANE_W +: mem_pkg::LANE_W] = data[l*mem_pkg::LANE_W +: mem_pkg::LANE_W];
      end
    end
    if (wr) begin
      shadow[adr] = nxt;
    end
    return old;
  endfunction

  function automatic logic hits_subbank(input int b, input logic [mem_pkg::ADDR_W-1:0] adr,
                                        input logic [mem_pkg::RBANK_W-1:0] rb);
    return (int'(adr[mem_pkg::BANK_W-1:0]) == b) &&
           (adr[mem_pkg::ADDR_W-1 -: mem_pkg::RBANK_W] == rb);
  endfunction

  function automatic logic refr_due();
    return since >= mem_pkg::REF_PERIOD;
  endfunction

  task automatic drive(input logic rd, input logic [mem_pkg::ADDR_W-1:0] ra,
                       input logic wr, input logic [mem_pkg::ADDR_W-1:0] wa,
                       input logic [mem_pkg::NUM_LANES-1:0] lanes,
                       input logic [mem_pkg::WORD_W-1:0] data, input logic rf);
    @(posedge clk);
    #1;
    since = since + 1;
    if (rf) begin
      since = 0;
    end
    refr   = rf;
    read   = rd;
    rd_adr = ra;
    write  = wr;
    wr_adr = wa;
    wren   = lanes;
    din    = data;
    if (rd) begin
      exp_q.push_back(ref_word(ra, 1'b0, '0, '0));
    end
    if (wr) begin
      void'(ref_word(wa, 1'b1, lanes, data));
    end
  endtask

  task automatic idle_cycle(input logic rf);
    drive(1'b0, '0, 1'b0, '0, '0, '0, rf);
  endtask

  task automatic check_idle_outputs();
    compare("ready", 32'(ready), 32'd0);
    compare("rd_vld", 32'(rd_vld), 32'd0);
    compare("t1_read", 32'(t1_read), 32'd0);
    compare("t1_write", 32'(t1_write), 32'd0);
    compare("t1_refr", 32'(t1_refr), 32'd0);
  endtask

  // Read data and refresh checks, sampled mid-cycle.
  always @(negedge clk) begin : monitor
    logic exp_vld;
    logic acc;
    logic exp_refr;
    if (mon_on) begin
      compare("ready", 32'(ready), 32'd1);
      exp_vld = rd_hist[mem_pkg::RD_DELAY-1];
      compare("rd_vld", 32'(rd_vld), 32'(exp_vld));
      if (exp_vld) begin
        if (exp_q.size() == 0) begin
          report_failure("read data due with no read outstanding");
        end
        compare("rd_dout", rd_dout, exp_q.pop_front());
      end
      for (int i = mem_pkg::RD_DELAY - 1; i > 0; i--) begin
        rd_hist[i] = rd_hist[i-1];
      end
      rd_hist[0] = read;
      for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
        acc = (read && hits_subbank(b, rd_adr, exp_rbank[b])) ||
              (write && hits_subbank(b, wr_adr, exp_rbank[b]));
        if (refr) begin
          if (pend[b]) begin
            report_failure($sformatf("refr came before bank %0d finished its refresh", b));
          end
          pend[b] = 1'b1;
        end
        exp_refr = pend[b] && !acc;
        compare($sformatf("t1_refr[%0d]", b), 32'(t1_refr[b]), 32'(exp_refr));
        if (exp_refr) begin
          compare($sformatf("t1_rbank[%0d]", b),
                  32'(t1_rbank[b*mem_pkg::RBANK_W +: mem_pkg::RBANK_W]), 32'(exp_rbank[b]));
          if (int'(exp_rbank[b]) == mem_pkg::NUM_RBANKS - 1) begin
            exp_rbank[b] = '0;
          end else begin
            exp_rbank[b] = exp_rbank[b] + 1'b1;
          end
          pend[b] = 1'b0;
        end
      end
    end
  end

  initial begin : stimulus
    logic [mem_pkg::ADDR_W-1:0]  ra;
    logic [mem_pkg::ADDR_W-1:0]  wa;
    logic [mem_pkg::RBANK_W-1:0] rb;
    void'($urandom(32'hbbea74f1));
    arst_n = 1'b0;
    refr   = 1'b0;
    write  = 1'b0;
    wr_adr = '0;
    wren   = '0;
    din    = '0;
    read   = 1'b0;
    rd_adr = '0;
    mon_on = 1'b0;
    since  = mem_pkg::REF_PERIOD;
    pend   = '0;
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      exp_rbank[b] = '0;
    end
    for (int i = 0; i < mem_pkg::RD_DELAY; i++) begin
      rd_hist[i] = 1'b0;
    end
    for (int a = 0; a < (1 << mem_pkg::ADDR_W); a++) begin
      shadow[a] = '0;
    end

    repeat (4) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();
    @(negedge clk);
    compare("ready", 32'(ready), 32'd1);
    @(posedge clk);
    #1;
    mon_on = 1'b1;

    // Full words everywhere, then read all back.
    for (int a = 0; a < (1 << mem_pkg::ADDR_W); a++) begin
      drive(1'b0, '0, 1'b1, mem_pkg::ADDR_W'(a), '1, $urandom(), refr_due());
    end
    for (int a = 0; a < (1 << mem_pkg::ADDR_W); a++) begin
      drive(1'b1, mem_pkg::ADDR_W'(a), 1'b0, '0, '0, '0, refr_due());
    end

    // Partial write, then every slot of that physical row.
    for (int n = 0; n < 48; n++) begin
      wa = mem_pkg::ADDR_W'($urandom());
      drive(1'b0, '0, 1'b1, wa, mem_pkg::NUM_LANES'($urandom()), $urandom(), refr_due());
      for (int s = 0; s < mem_pkg::WORDS_PER_ROW; s++) begin
        ra = wa;
        ra[mem_pkg::BANK_W +: mem_pkg::WSEL_W] = mem_pkg::WSEL_W'(s);
        drive(1'b1, ra, 1'b0, '0, '0, '0, refr_due());
      end
    end

    // Read and write together, always in different banks.
    for (int n = 0; n < 300; n++) begin
      ra = mem_pkg::ADDR_W'($urandom());
      wa = mem_pkg::ADDR_W'($urandom());
      if (wa[mem_pkg::BANK_W-1:0] == ra[mem_pkg::BANK_W-1:0]) begin
        wa[mem_pkg::BANK_W-1:0] = ra[mem_pkg::BANK_W-1:0] + 1'b1;
      end
      drive(1'b1, ra, 1'b1, wa, mem_pkg::NUM_LANES'($urandom()), $urandom(), refr_due());
    end

    // Keep bank 0 on its pending sub-bank so the refresh waits.
    for (int i = 0; i < 2 * mem_pkg::REF_PERIOD && (!refr_due() || pend != '0); i++) begin
      idle_cycle(1'b0);
    end
    if (!refr_due() || pend != '0) begin
      report_failure("refresh did not settle before the deferral test");
    end
    rb = exp_rbank[0];
    for (int i = 0; i < 6; i++) begin
      ra = mem_pkg::ADDR_W'($urandom());
      ra[mem_pkg::ADDR_W-1 -: mem_pkg::RBANK_W] = rb;
      ra[mem_pkg::BANK_W-1:0] = '0;
      drive(1'b1, ra, 1'b0, '0, '0, '0, i == 0);
    end

    for (int i = 0; i < 64 && (exp_q.size() != 0 || pend != '0); i++) begin
      idle_cycle(1'b0);
    end
    if (exp_q.size() != 0 || pend != '0) begin
      report_failure("reads or refreshes still outstanding at the end");
    end
    repeat (mem_pkg::RD_DELAY + 2) begin
      idle_cycle(1'b0);
    end
    @(negedge clk);
    #1;
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: bank_mem_top.f
common/mem_pkg.sv
bank/word_align.sv
bank/bank_refresh.sv
source/bank_router.sv
source/bank_mem_top.sv
sim/bank_model.sv
sim/tb_bank_mem.sv

// File: Makefile
TOP   := tb_bank_mem
FLIST := bank_mem_top.f

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f $(FLIST) \
		--top-module $(TOP) -o sim_$(TOP)

run: build
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "simulation did not finish"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f $(FLIST) \
		--top-module bank_mem_top

clean:
	rm -rf obj_dir sim.log
